// File: sram_bist_cfg.svh
`ifndef SRAM_BIST_CFG_SVH
`define SRAM_BIST_CFG_SVH

// ==========================================================================
// SRAM geometry
// ==========================================================================

// flat address = {word, part}
// part codes at and above APARTS are unused
`define BIST_ABITS      2  // part field width
`define BIST_APARTS     3  // valid parts per word
`define BIST_DEPTH      8  // words
`define BIST_ADDR_WIDTH 5  // word bits + part bits
`define BIST_DATA_WIDTH 8  // bits per part

// highest valid flat address
`define BIST_MAX_ADDR (((`BIST_DEPTH - 1) << `BIST_ABITS) + `BIST_APARTS - 1)

`endif

// File: bist_pkg.sv
`default_nettype none

`include "sram_bist_cfg.svh"

package bist_pkg;

  typedef enum logic [1:0] {
    BIST_INIT = 2'd0,
    BIST_BUSY = 2'd1,
    BIST_PASS = 2'd2,
    BIST_FAIL = 2'd3
  } bist_state_e;

  typedef enum logic [1:0] {
    PAT_P = 2'd0,  // checkerboard
    PAT_N = 2'd1,  // inverted checkerboard
    PAT_0 = 2'd2,
    PAT_1 = 2'd3
  } pat_sel_e;

  typedef enum logic {
    DN = 1'b0,
    UP = 1'b1
  } dir_e;

  // flat view for the bus, split view for part skipping and word parity
  typedef union packed {
    logic [`BIST_ADDR_WIDTH-1:0] flat;
    struct packed {
      logic [`BIST_ADDR_WIDTH-`BIST_ABITS-1:0] word;
      logic [`BIST_ABITS-1:0]                  part;
    } f;
  } mem_addr_u;

endpackage

`default_nettype wire

// File: march_if.sv
`timescale 1ns/1ns
`default_nettype none

interface march_if;

  logic                start;     // load sweep start value
  bist_pkg::dir_e      dir;
  logic                step_adv;  // last sub-access at this address
  logic                acc_en;
  logic                acc_we;
  bist_pkg::pat_sel_e  pat_sel;
  bist_pkg::mem_addr_u addr;
  logic                last;      // addr at end of sweep
  logic                cmp_valid;
  logic                cmp_ok;

  modport seq (
    output start, dir, step_adv, acc_en, acc_we, pat_sel,
    input  last, cmp_valid, cmp_ok
  );

  modport agen (
    input  start, dir, step_adv,
    output addr, last
  );

  modport dp (
    input  acc_en, acc_we, pat_sel, addr,
    output cmp_valid, cmp_ok
  );

endinterface

`default_nettype wire

// File: march_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module march_sequencer (
  input  wire                   clk,
  input  wire                   nrst,
  input  wire                   run,
  output logic                  bist_run,
  output bist_pkg::bist_state_e state,
  march_if.seq                  mif
);

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_WAIT,
    ST_UP_WP,
    ST_DN_RP_WN,
    ST_UP_RN_WP_RP_RP_WN,
    ST_DN_RN_WP,
    ST_UP_RP_WN_RN_RN_WP,
    ST_UP_RP,
    ST_UP_W0,
    ST_UP_R0_W1,
    ST_DN_R1_W0,
    ST_UP_R0,
    ST_FINISH
  } step_e;

  logic       run_meta;
  step_e      step;
  step_e      step_nxt;
  logic [2:0] sub;
  logic [2:0] sub_max;  // accesses per address - 1
  logic       sub_done;
  logic       fail;

  function automatic bist_pkg::dir_e step_dir(input step_e s);
    case (s)
      ST_DN_RP_WN, ST_DN_RN_WP, ST_DN_R1_W0: step_dir = bist_pkg::DN;
      default:                               step_dir = bist_pkg::UP;
    endcase
  endfunction

  // ==========================================================================
  // access decode per element and sub-step
  // ==========================================================================

  always_comb begin
    mif.acc_we  = 1'b0;
    mif.pat_sel = bist_pkg::PAT_P;
    sub_max     = 3'd0;
    case (step)
      ST_UP_WP: begin
        mif.acc_we = 1'b1;
      end
      ST_DN_RP_WN: begin
        sub_max     = 3'd1;
        mif.acc_we  = sub[0];
        mif.pat_sel = sub[0] ? bist_pkg::PAT_N : bist_pkg::PAT_P;
      end
      ST_UP_RN_WP_RP_RP_WN: begin
        sub_max     = 3'd4;
        mif.acc_we  = (sub == 3'd1) || (sub == 3'd4);
        mif.pat_sel = ((sub == 3'd0) || (sub == 3'd4)) ? bist_pkg::PAT_N : bist_pkg::PAT_P;
      end
      ST_DN_RN_WP: begin
        sub_max     = 3'd1;
        mif.acc_we  = sub[0];
        mif.pat_sel = sub[0] ? bist_pkg::PAT_P : bist_pkg::PAT_N;
      end
      ST_UP_RP_WN_RN_RN_WP: begin
        sub_max     = 3'd4;
        mif.acc_we  = (sub == 3'd1) || (sub == 3'd4);
        mif.pat_sel = ((sub == 3'd0) || (sub == 3'd4)) ? bist_pkg::PAT_P : bist_pkg::PAT_N;
      end
      ST_UP_W0: begin
        mif.acc_we  = 1'b1;
        mif.pat_sel = bist_pkg::PAT_0;
      end
      ST_UP_R0_W1: begin
        sub_max     = 3'd1;
        mif.acc_we  = sub[0];
        mif.pat_sel = sub[0] ? bist_pkg::PAT_1 : bist_pkg::PAT_0;
      end
      ST_DN_R1_W0: begin
        sub_max     = 3'd1;
        mif.acc_we  = sub[0];
        mif.pat_sel = sub[0] ? bist_pkg::PAT_0 : bist_pkg::PAT_1;
      end
      ST_UP_R0: begin
        mif.pat_sel = bist_pkg::PAT_0;
      end
      default: begin
        mif.acc_we = 1'b0;  // ST_UP_RP and idle states read or do nothing
      end
    endcase
  end

  assign mif.acc_en   = (step >= ST_UP_WP) && (step <= ST_UP_R0);
  assign sub_done     = (sub == sub_max);
  assign mif.step_adv = mif.acc_en && sub_done;
  assign step_nxt     = step_e'(step + 4'd1);
  assign fail         = mif.cmp_valid && !mif.cmp_ok && (state == bist_pkg::BIST_BUSY);

  // address restart lands on the same edge as the first access of an element
  assign mif.start = ((step == ST_WAIT) && bist_run) ||
                     (mif.step_adv && mif.last && (step != ST_UP_R0));
  assign mif.dir   = step_dir(step_nxt);

  // ==========================================================================
  // element walk
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!nrst) begin
      run_meta <= 1'b0;
      bist_run <= 1'b0;
      step     <= ST_IDLE;
      sub      <= 3'd0;
      state    <= bist_pkg::BIST_INIT;
    end else begin
      run_meta <= run;  // two-flop sync
      bist_run <= run_meta;
      case (step)
        ST_IDLE: begin
          if (!bist_run) begin
            state <= bist_pkg::BIST_INIT;
            step  <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (bist_run) begin
            state <= bist_pkg::BIST_BUSY;
            step  <= step_nxt;
            sub   <= 3'd0;
          end
        end
        ST_FINISH: begin  // final compare lands here
          step <= ST_IDLE;
          if (mif.cmp_ok) begin
            state <= bist_pkg::BIST_PASS;
          end
        end
        default: begin
          if (sub_done) begin
            sub <= 3'd0;
            if (mif.last) begin
              step <= step_nxt;
            end
          end else begin
            sub <= sub + 3'd1;
          end
        end
      endcase
      if (fail) begin  // abort
        state <= bist_pkg::BIST_FAIL;
        step  <= ST_IDLE;
        sub   <= 3'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: march_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_bist_cfg.svh"

module march_addr_gen (
  input wire    clk,
  input wire    nrst,
  march_if.agen mif
);

  localparam logic [`BIST_ABITS-1:0]      PART_TOP = `BIST_ABITS'(`BIST_APARTS - 1);
  localparam logic [`BIST_ADDR_WIDTH-1:0] ADDR_TOP = `BIST_ADDR_WIDTH'(`BIST_MAX_ADDR);

  bist_pkg::dir_e      dir_q;
  bist_pkg::mem_addr_u addr_nxt;

  // step through valid parts only, carry into word
  always_comb begin
    addr_nxt = mif.addr;
    if (dir_q == bist_pkg::UP) begin
      if (mif.addr.f.part >= PART_TOP) begin
        addr_nxt.f.word = mif.addr.f.word + 1'b1;
        addr_nxt.f.part = '0;
      end else begin
        addr_nxt.f.part = mif.addr.f.part + 1'b1;
      end
    end else begin
      if (mif.addr.f.part == '0) begin
        addr_nxt.f.word = mif.addr.f.word - 1'b1;
        addr_nxt.f.part = PART_TOP;
      end else begin
        addr_nxt.f.part = mif.addr.f.part - 1'b1;
      end
    end
  end

  assign mif.last = (dir_q == bist_pkg::UP) ? (mif.addr.flat == ADDR_TOP)
                                            : (mif.addr.flat == '0);

  always_ff @(posedge clk) begin
    if (!nrst) begin
      mif.addr <= '0;
      dir_q    <= bist_pkg::UP;
    end else if (mif.start) begin
      mif.addr.flat <= (mif.dir == bist_pkg::UP) ? '0 : ADDR_TOP;
      dir_q         <= mif.dir;
    end else if (mif.step_adv && !mif.last) begin
      mif.addr <= addr_nxt;  // holds at end of sweep
    end
  end

endmodule

`default_nettype wire

// File: march_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_bist_cfg.svh"

module march_datapath (
  input  wire                         clk,
  input  wire                         nrst,
  march_if.dp                         mif,
  output logic [`BIST_DATA_WIDTH-1:0] wdata,
  input  wire  [`BIST_DATA_WIDTH-1:0] rdata,
  output logic                        ce,
  output logic                        we,
  output logic                        oe
);

  localparam logic [`BIST_DATA_WIDTH-1:0] CHK = {`BIST_DATA_WIDTH/2{2'b10}};

  logic [`BIST_DATA_WIDTH-1:0] pattern;
  logic [`BIST_DATA_WIDTH-1:0] exp_q;    // expected data of last read
  logic                        valid_q;
  logic                        odd_word;

  assign ce       = mif.acc_en;
  assign we       = mif.acc_we;
  assign oe       = ce & ~we;
  assign odd_word = mif.addr.f.word[0];

  // ==========================================================================
  // pattern generation
  // ==========================================================================

  always_comb begin
    case (mif.pat_sel)
      bist_pkg::PAT_P: pattern = odd_word ? ~CHK : CHK;
      bist_pkg::PAT_N: pattern = odd_word ? CHK : ~CHK;
      bist_pkg::PAT_0: pattern = '0;
      default:         pattern = '1;
    endcase
  end

  assign wdata = pattern;

  // ==========================================================================
  // read compare one cycle after the access
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (!nrst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= oe;
    end
  end

  always_ff @(posedge clk) begin
    exp_q <= pattern;
  end

  assign mif.cmp_valid = valid_q;
  assign mif.cmp_ok    = (rdata == exp_q);

endmodule

`default_nettype wire

// File: sram_bist_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_bist_cfg.svh"

module sram_bist_top (
  input  wire                         clk,
  input  wire                         nrst,
  input  wire                         run,
  output logic                        bist_run,
  output bist_pkg::bist_state_e       bist_state,
  output logic                        ce,
  output logic                        we,
  output logic                        oe,
  output logic [`BIST_ADDR_WIDTH-1:0] addr,
  output logic [`BIST_DATA_WIDTH-1:0] wdata,
  input  wire  [`BIST_DATA_WIDTH-1:0] rdata
);

  march_if mif ();

  march_sequencer u_seq (
    .clk      (clk),
    .nrst     (nrst),
    .run      (run),
    .bist_run (bist_run),
    .state    (bist_state),
    .mif      (mif.seq)
  );

  march_addr_gen u_agen (
    .clk  (clk),
    .nrst (nrst),
    .mif  (mif.agen)
  );

  march_datapath u_dp (
    .clk   (clk),
    .nrst  (nrst),
    .mif   (mif.dp),
    .wdata (wdata),
    .rdata (rdata),
    .ce    (ce),
    .we    (we),
    .oe    (oe)
  );

  assign addr = mif.addr.flat;

endmodule

`default_nettype wire

// File: sram_bist_chk.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_bist_cfg.svh"

module sram_bist_chk (
  input wire                        clk,
  input wire                        nrst,
  input wire                        ce,
  input wire                        we,
  input wire                        oe,
  input wire [`BIST_ADDR_WIDTH-1:0] addr,
  input wire [1:0]                  bist_state
);

  a_oe_we_excl: assert property (@(posedge clk) disable iff (!nrst)
    !(oe && we) && (ce || !we))
    else $error("oe and we high together, or a write without ce");

  a_part_valid: assert property (@(posedge clk) disable iff (!nrst)
    ce |-> (addr[`BIST_ABITS-1:0] < `BIST_APARTS))
    else $error("access to an unused part code");

  a_state_known: assert property (@(posedge clk) disable iff (!nrst) !$isunknown(bist_state))
    else $error("bist_state unknown");

  a_ce_busy: assert property (@(posedge clk) disable iff (!nrst)
    ce |-> (bist_state == bist_pkg::BIST_BUSY))
    else $error("access outside of a busy test");

endmodule

bind sram_bist_top sram_bist_chk u_chk (
  .clk        (clk),
  .nrst       (nrst),
  .ce         (ce),
  .we         (we),
  .oe         (oe),
  .addr       (addr),
  .bist_state (bist_state)
);

`default_nettype wire

// File: tb_sram_bist.sv
`timescale 1ns/1ns
`default_nettype none

`include "sram_bist_cfg.svh"

module tb_sram_bist;

  localparam logic [`BIST_DATA_WIDTH-1:0] CHECKER = 8'haa;
  localparam int N_ROWS  = 4;
  localparam int N_VALID = `BIST_DEPTH * `BIST_APARTS;

  logic                        clk;
  logic                        nrst;
  logic                        run;
  logic                        bist_run;
  bist_pkg::bist_state_e       bist_state;
  logic                        ce;
  logic                        we;
  logic                        oe;
  logic [`BIST_ADDR_WIDTH-1:0] addr;
  logic [`BIST_DATA_WIDTH-1:0] wdata;
  logic [`BIST_DATA_WIDTH-1:0] rdata;

  logic [`BIST_DATA_WIDTH-1:0] mem [0:(1 << `BIST_ADDR_WIDTH)-1];
  logic                        rd_pend;
  logic [`BIST_ADDR_WIDTH-1:0] rd_addr;
  logic                        fault_en;
  logic                        fault_val;
  logic [`BIST_ADDR_WIDTH-1:0] fault_addr;
  int                          fault_bit;
  int                          n_rd;
  int                          n_wr;
  int                          n_checks;
  int                          n_errors;
  logic [`BIST_ADDR_WIDTH-1:0] log_addr [0:N_VALID-1];  // first sweep of accesses
  logic [`BIST_DATA_WIDTH-1:0] log_data [0:N_VALID-1];
  logic                        log_we   [0:N_VALID-1];
  logic                        log_oe   [0:N_VALID-1];
  logic [3:0]                  tbl      [0:N_ROWS-1];   // {fault on, stuck value, final state}

  sram_bist_top u_dut (
    .clk        (clk),
    .nrst       (nrst),
    .run        (run),
    .bist_run   (bist_run),
    .bist_state (bist_state),
    .ce         (ce),
    .we         (we),
    .oe         (oe),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==========================================================================
  // SRAM model with read data in the cycle after the access
  // ==========================================================================

  always @(negedge clk) begin
    if (rd_pend) begin
      rdata = mem[rd_addr];
      if (fault_en && (rd_addr == fault_addr)) begin
        rdata[fault_bit] = fault_val;  // stuck-at bit
      end
    end
    rd_pend = ce && oe;
    rd_addr = addr;
    if (ce) begin
      if (n_rd + n_wr < N_VALID) begin
        log_addr[n_rd + n_wr] = addr;
        log_data[n_rd + n_wr] = wdata;
        log_we[n_rd + n_wr]   = we;
        log_oe[n_rd + n_wr]   = oe;
      end
      if (we) begin
        mem[addr] = wdata;
        n_wr++;
      end else begin
        n_rd++;
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic wait_for_state(input logic [1:0] a, input logic [1:0] b,
                                input int limit, output logic ok);
    int n;
    ok = 1'b0;
    for (n = 0; (n < limit) && !ok; n++) begin
      @(negedge clk);
      ok = (bist_state == a) || (bist_state == b);
    end
  endtask

  // ==========================================================================
  // stimulus
  // ==========================================================================

  initial begin : stim
    int                          seed;
    int                          row;
    int                          i;
    logic                        ok;
    logic                        aborted;
    logic [1:0]                  exp_state;
    logic [`BIST_ADDR_WIDTH-1:0] a;
    logic [`BIST_DATA_WIDTH-1:0] d;
    seed       = 6314;
    i          = $urandom(seed);
    nrst       = 1'b0;
    run        = 1'b0;
    rdata      = '0;
    rd_pend    = 1'b0;
    rd_addr    = '0;
    fault_en   = 1'b0;
    fault_val  = 1'b0;
    fault_addr = '0;
    fault_bit  = 0;
    n_rd       = 0;
    n_wr       = 0;
    n_checks   = 0;
    n_errors   = 0;
    aborted    = 1'b0;
    tbl[0] = {1'b0, 1'b0, bist_pkg::BIST_PASS};
    tbl[1] = {1'b1, 1'b1, bist_pkg::BIST_FAIL};
    tbl[2] = {1'b0, 1'b0, bist_pkg::BIST_PASS};  // recovery after a fail
    tbl[3] = {1'b1, 1'b0, bist_pkg::BIST_FAIL};
    for (i = 0; i < (1 << `BIST_ADDR_WIDTH); i++) begin
      mem[i] = 8'((i * 29) ^ 8'h5a);
    end
    repeat (3) @(negedge clk);
    nrst = 1'b1;
    @(negedge clk);
    check_value("bist_state", bist_state, bist_pkg::BIST_INIT);
    check_value("ce", ce, 1'b0);
    check_value("bist_run", bist_run, 1'b0);

    for (row = 0; (row < N_ROWS) && !aborted; row++) begin
      exp_state = tbl[row][1:0];
      run = 1'b0;
      wait_for_state(bist_pkg::BIST_INIT, bist_pkg::BIST_INIT, 20, ok);
      if (!ok) begin
        n_errors++;
        aborted = 1'b1;
        $display("timeout, engine did not return to idle in row %0d", row);
      end else begin
        fault_en   = tbl[row][3];
        fault_val  = tbl[row][2];
        fault_addr = `BIST_ADDR_WIDTH'((($urandom % `BIST_DEPTH) << `BIST_ABITS) +
                                       ($urandom % `BIST_APARTS));
        fault_bit  = $urandom % `BIST_DATA_WIDTH;
        n_rd       = 0;
        n_wr       = 0;
        for (i = 0; i < N_VALID; i++) begin
          log_we[i] = 1'b0;
          log_oe[i] = 1'b1;
        end
        run = 1'b1;
        wait_for_state(bist_pkg::BIST_PASS, bist_pkg::BIST_FAIL, 2000, ok);
        if (!ok) begin
          n_errors++;
          aborted = 1'b1;
          $display("timeout, test did not finish in row %0d", row);
        end else begin
          check_value("bist_state", bist_state, exp_state);
          if (exp_state == bist_pkg::BIST_FAIL) begin
            repeat (3) begin
              @(negedge clk);
              check_value("ce", ce, 1'b0);  // access stopped
            end
          end else begin
            check_value("read count", n_rd, 12 * N_VALID);
            check_value("write count", n_wr, 10 * N_VALID);
            for (i = 0; i < N_VALID; i++) begin
              a = `BIST_ADDR_WIDTH'(((i / `BIST_APARTS) << `BIST_ABITS) + (i % `BIST_APARTS));
              check_value($sformatf("mem[%0d]", a), mem[a], '0);
            end
          end
          for (i = 0; i < N_VALID; i++) begin
            a = `BIST_ADDR_WIDTH'(((i / `BIST_APARTS) << `BIST_ABITS) + (i % `BIST_APARTS));
            d = ((i / `BIST_APARTS) % 2) ? ~CHECKER : CHECKER;  // swap on odd words
            check_value("we", log_we[i], 1'b1);
            check_value("oe", log_oe[i], 1'b0);
            check_value("addr", log_addr[i], a);
            check_value("wdata", log_data[i], d);
          end
        end
      end
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
bist_pkg.sv
march_if.sv
march_sequencer.sv
march_addr_gen.sv
march_datapath.sv
sram_bist_top.sv
sram_bist_chk.sv
tb_sram_bist.sv

// File: Bender.yml
package:
  name: sram_bist

sources:
  - include_dirs:
      - .
    files:
      - bist_pkg.sv
      - march_if.sv
      - march_sequencer.sv
      - march_addr_gen.sv
      - march_datapath.sv
      - sram_bist_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - sram_bist_chk.sv
      - tb_sram_bist.sv
